// ==== sources.f ====
verilog/tcdm_pkg.sv
verilog/amo_alu.sv
verilog/tcdm_req_ctrl.sv
verilog/tcdm_resp_buffer.sv
verilog/tcdm_amo_adapter.sv
dv/sram_model.sv
dv/tcdm_amo_adapter_tb.sv

// ==== Bender.yml ====
package:
  name: tcdm_amo_adapter

sources:
  - verilog/tcdm_pkg.sv
  - verilog/amo_alu.sv
  - verilog/tcdm_req_ctrl.sv
  - verilog/tcdm_resp_buffer.sv
  - verilog/tcdm_amo_adapter.sv
  - target: test
    files:
      - dv/sram_model.sv
      - dv/tcdm_amo_adapter_tb.sv

// ==== dv/tcdm_amo_adapter_tb.sv ====
// ----------------------------------------------------------
// TCDM AMO adapter testbench
// Applies a table of loads, stores and atomics, keeps a
// reference memory and checks every response in order
// under random response back-pressure
// ----------------------------------------------------------

`timescale 1ns/100ps

module tcdm_amo_adapter_tb import tcdm_pkg::*; ();

  localparam bit          register_amo   = 1'b0;
  localparam int unsigned busy_cycles    = register_amo ? 2 : 1;
  localparam int unsigned timeout_cycles = 200;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      req_valid_i;
  logic      req_ready_o;
  tcdm_req_t req_i;
  logic      rsp_valid_o;
  logic      rsp_ready_i;
  tcdm_rsp_t rsp_o;
  sram_req_t sram_o;
  data_t     sram_rdata_i;

  // Stimulus table and responses still owed by the DUT
  tcdm_req_t   stim_q [$];
  tcdm_rsp_t   expected_q [$];
  tcdm_rsp_t   expected_rsp;
  data_t       ref_mem [addr_t];
  logic [31:0] lcg_state = 32'h745e55f6;

  always #10 clk_i = ~clk_i;

  tcdm_amo_adapter #(
    .register_amo(register_amo)
  ) DUT (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o),
    .sram_o      (sram_o),
    .sram_rdata_i(sram_rdata_i)
  );

  sram_model u_sram (
    .clk_i  (clk_i),
    .sram_i (sram_o),
    .rdata_o(sram_rdata_i)
  );

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "Run aborted");
  endtask

  // Unwritten words hold the SRAM's start-up pattern
  function automatic data_t read_ref(addr_t addr);
    if (ref_mem.exists(addr)) begin
      return ref_mem[addr];
    end
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic data_t merge_bytes(data_t old_word, data_t new_word, be_t be);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < be_width; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // New memory word of an atomic
  function automatic data_t amo_expected(amo_op_e op, data_t mem_word, data_t operand);
    case (op)
      amo_swap: return operand;
      amo_add:  return mem_word + operand;
      amo_and:  return mem_word & operand;
      amo_or:   return mem_word | operand;
      amo_xor:  return mem_word ^ operand;
      amo_max:  return ($signed(mem_word) > $signed(operand)) ? mem_word : operand;
      amo_maxu: return (mem_word > operand) ? mem_word : operand;
      amo_min:  return ($signed(mem_word) < $signed(operand)) ? mem_word : operand;
      amo_minu: return (mem_word < operand) ? mem_word : operand;
      default:  return mem_word;
    endcase
  endfunction

  task automatic add_entry(input amo_op_e op, input logic write, input addr_t addr,
                           input data_t wdata, input be_t be);
    tcdm_req_t entry;
    entry.addr  = addr;
    entry.amo   = op;
    entry.write = write;
    entry.wdata = wdata;
    entry.be    = be;
    // Tag is unique per entry
    entry.meta  = meta_t'(8'h20 + stim_q.size());
    stim_q.push_back(entry);
  endtask

  // ----------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------
  task automatic build_table();
    amo_op_e     op;
    logic        top_bit_pair;
    addr_t       addr;
    logic [31:0] r;
    // Partial stores, then loads of the merged words
    add_entry(amo_none, 1'b1, 32'h0000_0000, 32'h1122_3344, 4'b0101);
    add_entry(amo_none, 1'b1, 32'h0000_0004, 32'haabb_ccdd, 4'b1100);
    add_entry(amo_none, 1'b0, 32'h0000_0000, 32'h0, 4'hf);
    add_entry(amo_none, 1'b0, 32'h0000_0004, 32'h0, 4'hf);
    add_entry(amo_none, 1'b1, 32'h0000_0000, 32'h5566_7788, 4'b1010);
    add_entry(amo_none, 1'b1, 32'h0000_0008, 32'hdead_beef, 4'b0001);
    add_entry(amo_none, 1'b0, 32'h0000_0000, 32'h0, 4'hf);
    add_entry(amo_none, 1'b0, 32'h0000_0008, 32'h0, 4'hf);
    // Each atomic sets the word, runs the AMO and loads right after it
    for (int k = 0; k < 9; k++) begin
      op           = amo_op_e'(4'(k + 1));
      addr         = 32'h40 + 32'(k * 4);
      top_bit_pair = op inside {amo_max, amo_maxu, amo_min, amo_minu};
      add_entry(amo_none, 1'b1, addr, top_bit_pair ? 32'h8000_0010 : 32'h0f0f_1234, 4'hf);
      add_entry(op, 1'b0, addr, top_bit_pair ? 32'h0000_0020 : 32'hf0f0_0101, 4'hf);
      add_entry(amo_none, 1'b0, addr, 32'h0, 4'hf);
    end
    // Random mix on a small window of words
    repeat (48) begin
      r    = lcg_next();
      addr = 32'h100 + {r[18:16], 2'b00};
      case (r[31:30])
        2'd1:    add_entry(amo_none, 1'b1, addr, lcg_next(), be_t'(r[27:24]));
        2'd2:    add_entry(amo_op_e'(4'(r[11:8] % 9 + 1)), 1'b0, addr, lcg_next(), 4'hf);
        default: add_entry(amo_none, 1'b0, addr, 32'h0, 4'hf);
      endcase
    end
  endtask

  // Reference memory update at the handshake
  task automatic record_request(input tcdm_req_t req);
    data_t     old_word;
    tcdm_rsp_t rsp;
    old_word  = read_ref(req.addr);
    rsp.rdata = old_word;
    rsp.meta  = req.meta;
    if (req.amo inside {[amo_swap:amo_minu]}) begin
      expected_q.push_back(rsp);
      ref_mem[req.addr] = amo_expected(req.amo, old_word, req.wdata);
    end else if (req.write) begin
      ref_mem[req.addr] = merge_bytes(old_word, req.wdata, req.be);
    end else begin
      expected_q.push_back(rsp);
    end
  endtask

  // Entries go out back to back and each is held until accepted
  task automatic apply_table();
    int unsigned cycles;
    int unsigned busy_left;
    logic        accepted;
    busy_left = 0;
    foreach (stim_q[i]) begin
      req_valid_i <= 1'b1;
      req_i       <= stim_q[i];
      cycles   = 0;
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clk_i);
        // Requests stay blocked while an AMO writes back
        if (busy_left != 0) begin
          check_value("req_ready_o", 32'(req_ready_o), 32'h0);
          busy_left--;
        end
        accepted = req_ready_o;
        if (!accepted) begin
          cycles++;
          if (cycles > timeout_cycles) begin
            abort_run("Request was never accepted by the DUT");
          end
        end
      end
      record_request(stim_q[i]);
      busy_left = (stim_q[i].amo inside {[amo_swap:amo_minu]}) ? busy_cycles : 0;
      @(posedge clk_i);
    end
    req_valid_i <= 1'b0;
  endtask

  task automatic wait_for_drain();
    int unsigned cycles;
    cycles = 0;
    while (expected_q.size() != 0) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > timeout_cycles) begin
        abort_run("Responses still missing after all requests were sent");
      end
    end
  endtask

  // ----------------------------------------------------------
  // Response side
  // ----------------------------------------------------------
  always @(posedge clk_i) begin
    if (rst_ni) begin
      // Ready about three cycles in four
      rsp_ready_i <= (lcg_next() >> 30) != 32'd0;
    end
  end

  always @(negedge clk_i) begin
    if (rst_ni && rsp_valid_o && rsp_ready_i) begin
      if (expected_q.size() == 0) begin
        abort_run("DUT returned a response with no read outstanding");
      end else begin
        expected_rsp = expected_q.pop_front();
        check_value("rsp_o.rdata", rsp_o.rdata, expected_rsp.rdata);
        check_value("rsp_o.meta", 32'(rsp_o.meta), 32'(expected_rsp.meta));
      end
    end
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    build_table();
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Idle outputs right after reset
    @(negedge clk_i);
    check_value("rsp_valid_o", 32'(rsp_valid_o), 32'h0);
    check_value("sram_o.req", 32'(sram_o.req), 32'h0);
    check_value("req_ready_o", 32'(req_ready_o), 32'h1);
    @(posedge clk_i);
    apply_table();
    wait_for_drain();
    // Extra responses would show up here
    repeat (10) @(negedge clk_i);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== dv/sram_model.sv ====
// ----------------------------------------------------------
// SRAM model
// Behavioral single-ported SRAM with byte enables and one
// cycle of read latency. Used as the DUT's memory
// ----------------------------------------------------------

`timescale 1ns/100ps

module sram_model import tcdm_pkg::*; #(
  parameter int unsigned num_words = 256
) (
  input  logic      clk_i,
  input  sram_req_t sram_i,
  output data_t     rdata_o
);

  localparam int unsigned idx_width = $clog2(num_words);

  data_t                mem [num_words];
  logic [idx_width-1:0] idx;

  // Word index from the byte address
  assign idx = sram_i.addr[idx_width+1:2];

  // Start-up contents, a function of the full byte address
  function automatic data_t initial_word(addr_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  initial begin
    for (int i = 0; i < num_words; i++) begin
      mem[i] = initial_word(addr_t'(i) << 2);
    end
  end

  // Write merges bytes, read data appears on the next cycle
  always @(posedge clk_i) begin
    if (sram_i.req) begin
      if (sram_i.write) begin
        for (int b = 0; b < be_width; b++) begin
          if (sram_i.be[b]) begin
            mem[idx][8*b +: 8] <= sram_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[idx];
      end
    end
  end

endmodule

// ==== verilog/tcdm_amo_adapter.sv ====
// ----------------------------------------------------------
// TCDM AMO adapter
// Sits in front of one single-ported SRAM. Converts the
// request stream to SRAM strobes, returns read data with
// its tag and executes atomics as read then write
// ----------------------------------------------------------

`timescale 1ns/100ps

module tcdm_amo_adapter import tcdm_pkg::*; #(
  // Registers the AMO result at the cost of one more cycle
  parameter bit register_amo = 1'b0
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Request stream
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  tcdm_req_t req_i,
  // Response stream
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i,
  output tcdm_rsp_t rsp_o,
  // SRAM port
  output sram_req_t sram_o,
  input  data_t     sram_rdata_i
);

  // Controller to response buffer
  logic    read_issued;
  meta_t   meta;
  logic    rsp_stall;
  // Controller to ALU
  amo_op_e amo_op;
  data_t   amo_operand;
  logic    amo_capture;
  data_t   amo_result;

  tcdm_req_ctrl #(
    .register_amo(register_amo)
  ) u_req_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_i        (req_i),
    .rsp_stall_i  (rsp_stall),
    .amo_result_i (amo_result),
    .amo_op_o     (amo_op),
    .amo_operand_o(amo_operand),
    .amo_capture_o(amo_capture),
    .read_issued_o(read_issued),
    .meta_o       (meta),
    .sram_o       (sram_o)
  );

  // Old word is taken straight from the SRAM read data
  amo_alu #(
    .register_amo(register_amo)
  ) u_amo_alu (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .op_i       (amo_op),
    .operand_a_i(sram_rdata_i),
    .operand_b_i(amo_operand),
    .capture_i  (amo_capture),
    .result_o   (amo_result)
  );

  tcdm_resp_buffer u_resp_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .read_issued_i(read_issued),
    .meta_i       (meta),
    .sram_rdata_i (sram_rdata_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_o        (rsp_o),
    .rsp_stall_o  (rsp_stall)
  );

endmodule

// ==== verilog/tcdm_resp_buffer.sv ====
// ----------------------------------------------------------
// TCDM response buffer
// Keeps the tags of issued reads and pairs them with the
// SRAM read data, which arrives one cycle later. A
// fall-through register holds data under back-pressure
// ----------------------------------------------------------

`timescale 1ns/100ps

module tcdm_resp_buffer import tcdm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Tag of a read issued this cycle
  input  logic      read_issued_i,
  input  meta_t     meta_i,
  input  data_t     sram_rdata_i,
  // Response stream
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i,
  output tcdm_rsp_t rsp_o,
  output logic      rsp_stall_o
);

  // ----------------------------------------------------------
  // Tag buffer, two entries
  // ----------------------------------------------------------
  meta_t      tag_mem_q [2];
  logic       tag_wr_ptr_q;
  logic       tag_rd_ptr_q;
  logic [1:0] tag_cnt_q;
  logic       tag_valid;
  logic       tag_full;
  logic       tag_pop;

  // Read data path
  logic  read_valid_q;
  logic  data_full_q;
  data_t data_q;
  logic  data_valid;
  logic  rsp_accepted;

  assign tag_valid = (tag_cnt_q != 2'd0);
  assign tag_full  = (tag_cnt_q == 2'd2);
  assign tag_pop   = rsp_accepted;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tag_wr_ptr_q <= 1'b0;
      tag_rd_ptr_q <= 1'b0;
      tag_cnt_q    <= 2'd0;
    end else begin
      if (read_issued_i) begin
        tag_wr_ptr_q <= ~tag_wr_ptr_q;
      end
      if (tag_pop) begin
        tag_rd_ptr_q <= ~tag_rd_ptr_q;
      end
      // Count moves only when push and pop differ
      if (read_issued_i && !tag_pop) begin
        tag_cnt_q <= tag_cnt_q + 2'd1;
      end else if (!read_issued_i && tag_pop) begin
        tag_cnt_q <= tag_cnt_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (read_issued_i) begin
      tag_mem_q[tag_wr_ptr_q] <= meta_i;
    end
  end

  // ----------------------------------------------------------
  // Fall-through read data register
  // ----------------------------------------------------------
  // SRAM data shows up one cycle after the read strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_valid_q <= 1'b0;
      data_full_q  <= 1'b0;
    end else begin
      read_valid_q <= read_issued_i;
      // Park the data when it is not taken on arrival
      if (read_valid_q && !data_full_q && !rsp_accepted) begin
        data_full_q <= 1'b1;
      end else if (data_full_q && rsp_accepted) begin
        data_full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (read_valid_q && !data_full_q) begin
      data_q <= sram_rdata_i;
    end
  end

  assign data_valid = data_full_q | read_valid_q;

  // Tag always comes before its data
  assign rsp_valid_o  = tag_valid & data_valid;
  assign rsp_accepted = rsp_valid_o & rsp_ready_i;
  assign rsp_stall_o  = rsp_valid_o & ~rsp_ready_i;

  assign rsp_o.rdata = data_full_q ? data_q : sram_rdata_i;
  assign rsp_o.meta  = tag_mem_q[tag_rd_ptr_q];

  tag_no_overflow : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    read_issued_i |-> !tag_full)
    else $error("Tag pushed into a full response buffer");

  data_no_overflow : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    read_valid_q |-> !data_full_q)
    else $error("Read data arrived while the data register was occupied");

endmodule

// ==== verilog/tcdm_req_ctrl.sv ====
// ----------------------------------------------------------
// TCDM request controller
// Turns valid/ready requests into SRAM strobes and runs the
// read-modify-write of atomics. Requests are blocked while
// an AMO result is pending for write-back
// ----------------------------------------------------------

`timescale 1ns/100ps

module tcdm_req_ctrl import tcdm_pkg::*; #(
  parameter bit register_amo = 1'b0
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Requester side
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  tcdm_req_t req_i,
  // Response waiting and not taken
  input  logic      rsp_stall_i,
  // AMO ALU
  input  data_t     amo_result_i,
  output amo_op_e   amo_op_o,
  output data_t     amo_operand_o,
  output logic      amo_capture_o,
  // Tag handoff to the response buffer
  output logic      read_issued_o,
  output meta_t     meta_o,
  // SRAM port
  output sram_req_t sram_o
);

  typedef enum logic [1:0] {
    idle,
    do_amo,
    write_back_amo
  } state_e;

  // Cycles with requests blocked after an accepted AMO
  localparam int unsigned amo_busy_cycles = register_amo ? 2 : 1;

  state_e  state_q, state_d;
  logic    req_accepted;
  logic    is_amo;
  // Pending AMO
  amo_op_e amo_op_q;
  addr_t   amo_addr_q;
  data_t   amo_operand_q;

  assign is_amo       = req_i.amo inside {[amo_swap:amo_minu]};
  // Back-pressure on the response side also stalls requests
  assign req_ready_o  = (state_q == idle) & ~rsp_stall_i;
  assign req_accepted = req_valid_i & req_ready_o;

  // Every accepted read, AMO reads included, gets a response
  assign read_issued_o = req_accepted & (~req_i.write | is_amo);
  assign meta_o        = req_i.meta;

  assign amo_op_o      = amo_op_q;
  assign amo_operand_o = amo_operand_q;
  // Old word is on sram_rdata in do_amo
  assign amo_capture_o = (state_q == do_amo);

  // ----------------------------------------------------------
  // FSM and SRAM port
  // ----------------------------------------------------------
  always_comb begin
    state_d = state_q;

    // Default is a feed-through of the accepted request
    sram_o.req   = req_accepted;
    sram_o.addr  = req_i.addr;
    // AMO starts with a read of the old word
    sram_o.write = req_i.write & ~is_amo;
    sram_o.wdata = req_i.wdata;
    sram_o.be    = req_i.be;

    unique case (state_q)
      idle: begin
        if (req_accepted && is_amo) begin
          state_d = do_amo;
        end
      end
      do_amo: begin
        if (register_amo) begin
          // ALU registers the result this cycle
          state_d = write_back_amo;
        end else begin
          sram_o.req   = 1'b1;
          sram_o.addr  = amo_addr_q;
          sram_o.write = 1'b1;
          sram_o.wdata = amo_result_i;
          sram_o.be    = '1;
          state_d      = idle;
        end
      end
      write_back_amo: begin
        // Commit the registered result
        sram_o.req   = 1'b1;
        sram_o.addr  = amo_addr_q;
        sram_o.write = 1'b1;
        sram_o.wdata = amo_result_i;
        sram_o.be    = '1;
        state_d      = idle;
      end
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Operation, address and operand of the AMO in flight
  always_ff @(posedge clk_i) begin
    if (req_accepted && is_amo) begin
      amo_op_q      <= req_i.amo;
      amo_addr_q    <= req_i.addr;
      amo_operand_q <= req_i.wdata;
    end
  end

  // Nothing slips in between the AMO read and its write-back
  amo_blocks_requests : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (req_accepted && is_amo) |=> !(req_valid_i && req_ready_o) [*amo_busy_cycles])
    else $error("Request accepted while an AMO was still pending");

endmodule

// ==== verilog/amo_alu.sv ====
// ----------------------------------------------------------
// AMO ALU
// Combines the old memory word with the AMO operand
// through one shared 33-bit adder. The result can be cut
// by a register that loads on capture_i
// ----------------------------------------------------------

`timescale 1ns/100ps

module amo_alu import tcdm_pkg::*; #(
  parameter bit register_amo = 1'b0
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  amo_op_e op_i,
  // Old word straight from the SRAM
  input  data_t   operand_a_i,
  input  data_t   operand_b_i,
  input  logic    capture_i,
  output data_t   result_o
);

  logic                is_signed;
  logic                is_sub;
  logic [data_width:0] operand_a_ext;
  logic [data_width:0] operand_b_ext;
  logic [data_width:0] adder_b;
  logic [data_width:0] adder_sum;
  logic                a_less_b;
  data_t               result_d;

  // Min and max compare by subtraction, add needs no extension
  assign is_signed = op_i inside {amo_max, amo_min};
  assign is_sub    = op_i inside {amo_max, amo_maxu, amo_min, amo_minu};

  // Sign or zero extension to 33 bits
  assign operand_a_ext = {is_signed & operand_a_i[data_width-1], operand_a_i};
  assign operand_b_ext = {is_signed & operand_b_i[data_width-1], operand_b_i};

  // a - b as a + ~b + 1
  assign adder_b   = is_sub ? ~operand_b_ext : operand_b_ext;
  assign adder_sum = operand_a_ext + adder_b + {{data_width{1'b0}}, is_sub};
  // Difference fits in 33 bits, so its top bit is the sign
  assign a_less_b  = adder_sum[data_width];

  always_comb begin
    unique case (op_i)
      amo_swap: result_d = operand_b_i;
      amo_add:  result_d = adder_sum[data_width-1:0];
      amo_and:  result_d = operand_a_i & operand_b_i;
      amo_or:   result_d = operand_a_i | operand_b_i;
      amo_xor:  result_d = operand_a_i ^ operand_b_i;
      amo_max,
      amo_maxu: result_d = a_less_b ? operand_b_i : operand_a_i;
      amo_min,
      amo_minu: result_d = a_less_b ? operand_a_i : operand_b_i;
      default:  result_d = '0;
    endcase
  end

  // ----------------------------------------------------------
  // Optional result register
  // ----------------------------------------------------------
  if (register_amo) begin : gen_result_reg
    data_t result_q;

    always_ff @(posedge clk_i) begin
      if (capture_i) begin
        result_q <= result_d;
      end
    end
    assign result_o = result_q;
  end else begin : gen_result_comb
    assign result_o = result_d;
  end

  // Operation held by the controller must be a real atomic
  op_valid_on_capture : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    capture_i |-> op_i inside {[amo_swap:amo_minu]})
    else $error("AMO ALU captured an invalid operation %0h", op_i);

endmodule

// ==== verilog/tcdm_pkg.sv ====
// ----------------------------------------------------------
// TCDM AMO adapter package
// Bus widths, the AMO operation encoding and the structs
// carried on the request, response and SRAM ports
// ----------------------------------------------------------

package tcdm_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int unsigned addr_width = 32;
  // Only 32-bit words are supported by the AMO ALU
  localparam int unsigned data_width = 32;
  localparam int unsigned be_width   = data_width / 8;
  // Requester tag, returned untouched with the read data
  localparam int unsigned meta_width = 8;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [be_width-1:0]   be_t;
  typedef logic [meta_width-1:0] meta_t;

  // ----------------------------------------------------------
  // AMO encoding
  // ----------------------------------------------------------
  // Codes above minu are not atomics and act as plain accesses
  typedef enum logic [3:0] {
    amo_none = 4'h0,
    amo_swap = 4'h1,
    amo_add  = 4'h2,
    amo_and  = 4'h3,
    amo_or   = 4'h4,
    amo_xor  = 4'h5,
    amo_max  = 4'h6,
    amo_maxu = 4'h7,
    amo_min  = 4'h8,
    amo_minu = 4'h9
  } amo_op_e;

  // ----------------------------------------------------------
  // Port structs
  // ----------------------------------------------------------
  // Requester side, one beat per valid/ready handshake
  typedef struct packed {
    addr_t   addr;
    amo_op_e amo;
    logic    write;
    data_t   wdata;
    be_t     be;
    meta_t   meta;
  } tcdm_req_t;

  // Read data returned with the tag of its request
  typedef struct packed {
    data_t rdata;
    meta_t meta;
  } tcdm_rsp_t;

  // SRAM strobe bundle, read data comes back one cycle later
  typedef struct packed {
    logic  req;
    addr_t addr;
    logic  write;
    data_t wdata;
    be_t   be;
  } sram_req_t;

endpackage
